// File: compile.f
rtl/dbg_pkg.sv
rtl/dbg_cmd_decode.sv
rtl/dbg_tile_ctrl.sv
rtl/dbg_rsp_merge.sv
rtl/dbg_subsystem.sv
sim/dbg_checker.sv
sim/dbg_assertions.sv
sim/tb_dbg_subsystem.sv

// File: sim/tb_dbg_subsystem.sv
// Testbench for the debug-control subsystem.
// Commands come from a table applied in order; dbg_checker judges the replies.
// Inputs change on the falling clock edge.
`timescale 1ns/10ps

module tb_dbg_subsystem;

   import dbg_pkg::*;

   logic                 clk;
   logic                 rst_n_i;
   logic                 host_stb_i;
   dbg_word_t            host_word_i;
   logic                 rsp_stb_o;
   dbg_word_t            rsp_word_o;
   logic [NUM_TILES-1:0] cpu_stall_o;
   logic [NUM_TILES-1:0] cpu_reset_o;
   string                step_name [$];
   dbg_word_t            step_word [$];
   int unsigned          step_idle [$];
   logic                 table_ready = 1'b0;
   logic [31:0]          lcg_state;
   int unsigned          total_errors;
   int unsigned          drain;

   dbg_subsystem u_dbg_subsystem (.clk(clk), .rst_n_i(rst_n_i), .host_stb_i(host_stb_i),
                                  .host_word_i(host_word_i), .rsp_stb_o(rsp_stb_o),
                                  .rsp_word_o(rsp_word_o), .cpu_stall_o(cpu_stall_o),
                                  .cpu_reset_o(cpu_reset_o));

   dbg_checker u_checker (.clk(clk), .rst_n_i(rst_n_i), .host_stb_i(host_stb_i),
                          .host_word_i(host_word_i), .rsp_stb_i(rsp_stb_o),
                          .rsp_word_i(rsp_word_o), .cpu_stall_i(cpu_stall_o),
                          .cpu_reset_i(cpu_reset_o));

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic dbg_word_t make_word(dbg_kind_t kind, tile_id_t tile, dbg_addr_t addr,
                                           dbg_data_t data);
      return {kind, tile, addr, data};
   endfunction

   task automatic add_step(input string name, input dbg_word_t word, input int unsigned idle);
      step_name.push_back(name);
      step_word.push_back(word);
      step_idle.push_back(idle);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      dbg_data_t   fill;
      dbg_data_t   mark;
      rnd  = lcg_next();
      fill = rnd[23:16];
      rnd  = lcg_next();
      // Tile 2 value has to stand apart from the broadcast fill
      mark = (rnd[23:16] == fill) ? ~fill : rnd[23:16];
      for (int t = 0; t < NUM_TILES; t++) begin
         add_step("reset_ctrl", make_word(KIND_READ, tile_id_t'(t), REG_CTRL, '0), 2);
      end
      add_step("scratch_fill", make_word(KIND_BCAST, 2'd0, REG_SCRATCH, fill), 0);
      for (int t = 0; t < NUM_TILES; t++) begin
         add_step("scratch_fill", make_word(KIND_READ, tile_id_t'(t), REG_SCRATCH, '0), 0);
      end
      add_step("scratch_one", make_word(KIND_WRITE, 2'd2, REG_SCRATCH, mark), 0);
      for (int t = 0; t < NUM_TILES; t++) begin
         add_step("scratch_one", make_word(KIND_READ, tile_id_t'(t), REG_SCRATCH, '0), 1);
      end
      // A response kind from the host must change nothing
      add_step("rsp_ignored", make_word(KIND_RSP, 2'd1, REG_SCRATCH, ~fill), 1);
      add_step("rsp_ignored", make_word(KIND_READ, 2'd1, REG_SCRATCH, '0), 3);
      add_step("bcast_ctrl", make_word(KIND_BCAST, 2'd0, REG_CTRL, 8'h01), 2);
      for (int t = 0; t < NUM_TILES; t++) begin
         add_step("bcast_ctrl", make_word(KIND_READ, tile_id_t'(t), REG_CTRL, '0), 0);
         add_step("tile_id", make_word(KIND_READ, tile_id_t'(t), REG_TILE_ID, '0), 1);
      end
      add_step("unknown_addr", make_word(KIND_READ, 2'd0, 4'h7, '0), 1);
      add_step("unknown_addr", make_word(KIND_READ, 2'd3, 4'hc, '0), 1);
      add_step("stall_count", make_word(KIND_WRITE, 2'd0, REG_CTRL, 8'h00), 20);
      add_step("stall_count", make_word(KIND_WRITE, 2'd0, REG_CTRL, 8'h01), 3);
      add_step("stall_count", make_word(KIND_READ, 2'd0, REG_COUNT, '0), 25);
      add_step("stall_count", make_word(KIND_READ, 2'd0, REG_COUNT, '0), 3);
      add_step("run_count", make_word(KIND_WRITE, 2'd0, REG_CTRL, 8'h00), 10);
      add_step("run_count", make_word(KIND_READ, 2'd0, REG_COUNT, '0), 25);
      add_step("run_count", make_word(KIND_READ, 2'd0, REG_COUNT, '0), 3);
      // Tiles 1 and 2 run with events on, tile 3 stays stalled
      add_step("events", make_word(KIND_WRITE, 2'd1, REG_CTRL, 8'h04), 0);
      add_step("events", make_word(KIND_WRITE, 2'd2, REG_CTRL, 8'h04), 2);
      for (int k = 0; k < 8; k++) begin
         add_step("events", make_word(KIND_READ, tile_id_t'(1 + k % 2), REG_COUNT, '0), 40);
      end
   endtask

   task automatic send_step(input int i);
      @(negedge clk);
      u_checker.set_test(step_name[i]);
      host_stb_i  = 1'b1;
      host_word_i = step_word[i];
      repeat (step_idle[i]) begin
         @(negedge clk);
         host_stb_i = 1'b0;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      wait (table_ready);
      repeat (step_word.size() * 300 + 200) @(posedge clk);
      $display("Timeout: the command table did not finish in time");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      rst_n_i     = 1'b1;
      host_stb_i  = 1'b0;
      host_word_i = '0;
      lcg_state   = 32'hb10f;
      build_table();
      table_ready = 1'b1;
      // Reset falls just after time zero
      #1;
      rst_n_i = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      for (int i = 0; i < step_word.size(); i++) begin
         send_step(i);
      end
      @(negedge clk);
      host_stb_i = 1'b0;
      drain = 0;
      while (u_checker.pending_reads() != 0 && drain < 20) begin
         @(negedge clk);
         drain++;
      end
      u_checker.check_events(4'b0110);
      total_errors = u_checker.value_errors + u_checker.protocol_errors +
                     u_dbg_subsystem.u_rsp_merge.u_merge_assertions.fail_count;
      $display("Errors: %0d value, %0d protocol, %0d assertion", u_checker.value_errors,
               u_checker.protocol_errors,
               u_dbg_subsystem.u_rsp_merge.u_merge_assertions.fail_count);
      if (total_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: sim/dbg_assertions.sv
// Protocol rules of the response merger, bound into every dbg_rsp_merge.
// The reply and kind rules are held off while reset is low.
`timescale 1ns/10ps

module dbg_assertions (
   input logic                          clk,
   input logic                          rst_n_i,
   input logic [dbg_pkg::NUM_TILES-1:0] tile_rsp_stb_i,
   input logic                          rsp_stb_i,
   input dbg_pkg::dbg_word_t            rsp_word_i
);

   import dbg_pkg::*;

   int unsigned fail_count = 0;

   // One read in flight per cycle, so one tile replies at most
   a_one_reply: assert property (@(posedge clk) disable iff (!rst_n_i)
                                 $onehot0(tile_rsp_stb_i))
      else begin
         $error("More than one tile reply strobe in one cycle");
         fail_count++;
      end

   a_quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !rsp_stb_i)
      else begin
         $error("Response strobe while reset is asserted");
         fail_count++;
      end

   a_rsp_kind: assert property (@(posedge clk) disable iff (!rst_n_i)
                                rsp_word_i[WORD_KIND_LSB +: KIND_W] == KIND_RSP)
      else begin
         $error("Response word without the response kind");
         fail_count++;
      end

endmodule

bind dbg_rsp_merge dbg_assertions u_merge_assertions (
   .clk            (clk),
   .rst_n_i        (rst_n_i),
   .tile_rsp_stb_i (tile_rsp_stb_i),
   .rsp_stb_i      (rsp_stb_o),
   .rsp_word_i     (rsp_word_o)
);

// File: sim/dbg_checker.sv
// Reference model and scoreboard for the debug-control subsystem.
// A read reply must arrive exactly 3 cycles after its host strobe.
// Event words are accepted only after a modeled counter wrap with events on.
`timescale 1ns/10ps

module dbg_checker (
   input logic                          clk,
   input logic                          rst_n_i,
   input logic                          host_stb_i,
   input dbg_pkg::dbg_word_t            host_word_i,
   input logic                          rsp_stb_i,
   input dbg_pkg::dbg_word_t            rsp_word_i,
   input logic [dbg_pkg::NUM_TILES-1:0] cpu_stall_i,
   input logic [dbg_pkg::NUM_TILES-1:0] cpu_reset_i
);

   import dbg_pkg::*;

   int unsigned          value_errors = 0;
   int unsigned          protocol_errors = 0;
   int unsigned          evt_seen [NUM_TILES];
   int unsigned          cyc = 0;
   string                test_name = "startup";
   logic [NUM_TILES-1:0] m_stall;
   logic [NUM_TILES-1:0] m_reset;
   logic [NUM_TILES-1:0] m_evt_en;
   logic [NUM_TILES-1:0] evt_owed;
   logic [NUM_TILES-1:0] wr_mask;
   dbg_data_t            m_scratch [NUM_TILES];
   dbg_data_t            m_count [NUM_TILES];
   dbg_addr_t            wr_addr;
   dbg_data_t            wr_data;
   int unsigned          exp_due [$];
   dbg_word_t            exp_word [$];
   string                exp_name [$];

   task automatic set_test(input string name);
      test_name = name;
   endtask

   function automatic int unsigned pending_reads();
      return exp_due.size();
   endfunction

   // Every tile in mask must have sent at least one event word
   task automatic check_events(input logic [NUM_TILES-1:0] mask);
      for (int t = 0; t < NUM_TILES; t++) begin
         if (mask[t] && evt_seen[t] == 0) begin
            protocol_errors++;
            $display("No event word arrived from tile %0d", t);
         end
      end
   endtask

   function automatic dbg_data_t model_read(input int t, input dbg_addr_t addr);
      case (addr)
         REG_CTRL:    return {5'd0, m_evt_en[t], m_reset[t], m_stall[t]};
         REG_SCRATCH: return m_scratch[t];
         REG_COUNT:   return m_count[t];
         REG_TILE_ID: return dbg_data_t'(t);
         default:     return '0;
      endcase
   endfunction

   always @(posedge clk) begin
      tile_id_t  ct;
      dbg_addr_t ca;
      if (!rst_n_i) begin
         m_stall  = {NUM_TILES{CTRL_RESET_VAL[CTRL_STALL_BIT]}};
         m_reset  = {NUM_TILES{CTRL_RESET_VAL[CTRL_RESET_BIT]}};
         m_evt_en = {NUM_TILES{CTRL_RESET_VAL[CTRL_EVT_EN_BIT]}};
         evt_owed = '0;
         wr_mask  = '0;
         for (int t = 0; t < NUM_TILES; t++) begin
            m_scratch[t] = '0;
            m_count[t]   = '0;
         end
      end else begin
         cyc++;
         if (cpu_stall_i !== m_stall || cpu_reset_i !== m_reset) begin
            value_errors++;
            $display("FAILED %s: stall/reset expected %b/%b, actual %b/%b", test_name,
                     m_stall, m_reset, cpu_stall_i, cpu_reset_i);
         end
         // A due read reply owns the slot, events only fill the gaps
         if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            if (!rsp_stb_i) begin
               protocol_errors++;
               $display("Read reply of %s did not arrive in its cycle", exp_name[0]);
            end else if (rsp_word_i !== exp_word[0]) begin
               value_errors++;
               $display("FAILED %s: expected %h, actual %h", exp_name[0], exp_word[0],
                        rsp_word_i);
            end
            void'(exp_due.pop_front());
            void'(exp_word.pop_front());
            void'(exp_name.pop_front());
         end else if (rsp_stb_i) begin
            ct = rsp_word_i[WORD_TILE_LSB +: TILE_ID_W];
            if (rsp_word_i === {KIND_RSP, ct, ADDR_EVENT, 8'h00} && evt_owed[ct]) begin
               evt_owed[ct] = 1'b0;
               evt_seen[ct]++;
            end else begin
               protocol_errors++;
               $display("Unexpected response word %h during %s", rsp_word_i, test_name);
            end
         end
         // Counter moves on the state before this edge, then last cycle's write lands
         for (int t = 0; t < NUM_TILES; t++) begin
            if (!m_stall[t] && !m_reset[t]) begin
               if (m_count[t] == 8'hff && m_evt_en[t]) begin
                  evt_owed[t] = 1'b1;
               end
               m_count[t] = m_count[t] + 8'd1;
            end
            if (wr_mask[t] && wr_addr == REG_CTRL) begin
               m_stall[t]  = wr_data[CTRL_STALL_BIT];
               m_reset[t]  = wr_data[CTRL_RESET_BIT];
               m_evt_en[t] = wr_data[CTRL_EVT_EN_BIT];
            end else if (wr_mask[t] && wr_addr == REG_SCRATCH) begin
               m_scratch[t] = wr_data;
            end
         end
         wr_mask = '0;
         if (host_stb_i) begin
            ct = host_word_i[WORD_TILE_LSB +: TILE_ID_W];
            ca = host_word_i[WORD_ADDR_LSB +: ADDR_W];
            case (dbg_kind_t'(host_word_i[WORD_KIND_LSB +: KIND_W]))
               KIND_WRITE: wr_mask[ct] = 1'b1;
               KIND_BCAST: wr_mask = '1;
               KIND_READ: begin
                  exp_due.push_back(cyc + 3);
                  exp_word.push_back({KIND_RSP, ct, ca, model_read(ct, ca)});
                  exp_name.push_back(test_name);
               end
               default: ;
            endcase
            wr_addr = ca;
            wr_data = host_word_i[DATA_W-1:0];
         end
      end
   end

endmodule

// File: rtl/dbg_subsystem.sv
// Debug-control subsystem top: decoder, four tile blocks, response merger.
// A read reply leaves rsp_stb_o three cycles after its host strobe.
// Host link has no back-pressure; one command per cycle at most.
`timescale 1ns/10ps

module dbg_subsystem (
   input  logic                               clk,
   input  logic                               rst_n_i,
   input  logic                               host_stb_i,
   input  dbg_pkg::dbg_word_t                 host_word_i,
   output logic                               rsp_stb_o,
   output dbg_pkg::dbg_word_t                 rsp_word_o,
   output logic [dbg_pkg::NUM_TILES-1:0]      cpu_stall_o,
   output logic [dbg_pkg::NUM_TILES-1:0]      cpu_reset_o
);

   import dbg_pkg::*;

   logic [NUM_TILES-1:0]         wr_stb;
   logic [NUM_TILES-1:0]         rd_stb;
   dbg_addr_t                    reg_addr;
   dbg_data_t                    reg_data;
   logic [NUM_TILES-1:0]         tile_rsp_stb;
   dbg_data_t [NUM_TILES-1:0]    tile_rsp_data;
   logic [NUM_TILES-1:0]         tile_evt_stb;

   dbg_cmd_decode
      u_cmd_decode(.clk         (clk),
                   .rst_n_i     (rst_n_i),
                   .host_stb_i  (host_stb_i),
                   .host_word_i (host_word_i),
                   .wr_stb_o    (wr_stb),
                   .rd_stb_o    (rd_stb),
                   .reg_addr_o  (reg_addr),
                   .reg_data_o  (reg_data));

   // One control block per tile, each with its own index
   for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
      dbg_tile_ctrl
         #(.TILE_ID(tile_id_t'(i)))
         u_tile_ctrl(.clk         (clk),
                     .rst_n_i     (rst_n_i),
                     .wr_stb_i    (wr_stb[i]),
                     .rd_stb_i    (rd_stb[i]),
                     .reg_addr_i  (reg_addr),
                     .reg_data_i  (reg_data),
                     .rsp_stb_o   (tile_rsp_stb[i]),
                     .rsp_data_o  (tile_rsp_data[i]),
                     .evt_stb_o   (tile_evt_stb[i]),
                     .cpu_stall_o (cpu_stall_o[i]),
                     .cpu_reset_o (cpu_reset_o[i]));
   end

   dbg_rsp_merge
      u_rsp_merge(.clk             (clk),
                  .rst_n_i         (rst_n_i),
                  .tile_rsp_stb_i  (tile_rsp_stb),
                  .tile_rsp_data_i (tile_rsp_data),
                  .tile_evt_stb_i  (tile_evt_stb),
                  .rd_addr_i       (reg_addr),
                  .rsp_stb_o       (rsp_stb_o),
                  .rsp_word_o      (rsp_word_o));

endmodule

// File: rtl/dbg_rsp_merge.sv
// Merges tile read replies and wrap events into one host response stream.
// A reply always wins; events wait in a pending bit per tile.
// At most one tile replies per cycle since the decoder issues one read at a time.
`timescale 1ns/10ps

module dbg_rsp_merge (
   input  logic                                       clk,
   input  logic                                       rst_n_i,
   input  logic [dbg_pkg::NUM_TILES-1:0]              tile_rsp_stb_i,
   input  dbg_pkg::dbg_data_t [dbg_pkg::NUM_TILES-1:0] tile_rsp_data_i,
   input  logic [dbg_pkg::NUM_TILES-1:0]              tile_evt_stb_i,
   input  dbg_pkg::dbg_addr_t                         rd_addr_i,
   output logic                                       rsp_stb_o,
   output dbg_pkg::dbg_word_t                         rsp_word_o
);

   import dbg_pkg::*;

   dbg_addr_t              rd_addr_q;
   logic                   rsp_any;
   tile_id_t               rsp_idx;
   logic                   evt_hit;
   tile_id_t               evt_idx;
   logic [NUM_TILES-1:0]   evt_clr;
   logic [NUM_TILES-1:0]   pend_q;
   logic                   out_stb_q;
   tile_id_t               out_tile_q;
   dbg_addr_t              out_addr_q;
   dbg_data_t              out_data_q;

   // Address lines up with the tile reply one cycle later
   always_ff @(posedge clk) begin
      rd_addr_q <= rd_addr_i;
   end

   assign rsp_any = |tile_rsp_stb_i;

   // Index of the replying tile
   always_comb begin
      rsp_idx = '0;
      for (int t = NUM_TILES - 1; t >= 0; t--) begin
         if (tile_rsp_stb_i[t]) begin
            rsp_idx = tile_id_t'(t);
         end
      end
   end

   // Lowest pending event
   always_comb begin
      evt_hit = 1'b0;
      evt_idx = '0;
      for (int t = NUM_TILES - 1; t >= 0; t--) begin
         if (pend_q[t]) begin
            evt_hit = 1'b1;
            evt_idx = tile_id_t'(t);
         end
      end
   end

   always_comb begin
      evt_clr = '0;
      if (evt_hit && !rsp_any) begin
         evt_clr[evt_idx] = 1'b1;
      end
   end

   // A fresh event on a granted tile stays pending
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q    <= '0;
         out_stb_q <= 1'b0;
      end else begin
         pend_q    <= (pend_q & ~evt_clr) | tile_evt_stb_i;
         out_stb_q <= rsp_any || evt_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_any) begin
         out_tile_q <= rsp_idx;
         out_addr_q <= rd_addr_q;
         out_data_q <= tile_rsp_data_i[rsp_idx];
      end else if (evt_hit) begin
         out_tile_q <= evt_idx;
         out_addr_q <= ADDR_EVENT;
         out_data_q <= '0;
      end
   end

   assign rsp_stb_o  = out_stb_q;
   // Kind is constant on every response word
   assign rsp_word_o = {KIND_RSP, out_tile_q, out_addr_q, out_data_q};

endmodule

// File: rtl/dbg_tile_ctrl.sv
// Control block of one tile: stall and reset, scratch, run-cycle counter.
// Reads reply one cycle after rd_stb_i; writes land one cycle after wr_stb_i.
// The counter only runs while stall and reset are both clear.
`timescale 1ns/10ps

module dbg_tile_ctrl #(
   parameter dbg_pkg::tile_id_t TILE_ID = '0
) (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 wr_stb_i,
   input  logic                 rd_stb_i,
   input  dbg_pkg::dbg_addr_t   reg_addr_i,
   input  dbg_pkg::dbg_data_t   reg_data_i,
   output logic                 rsp_stb_o,
   output dbg_pkg::dbg_data_t   rsp_data_o,
   output logic                 evt_stb_o,
   output logic                 cpu_stall_o,
   output logic                 cpu_reset_o
);

   import dbg_pkg::*;

   logic       stall_q;
   logic       reset_q;
   logic       evt_en_q;
   dbg_data_t  scratch_q;
   dbg_data_t  count_q;
   logic       run;
   logic       wrap;
   logic       rsp_stb_q;
   dbg_data_t  rsp_data_q;
   logic       evt_stb_q;
   dbg_data_t  rd_val;
   logic       wr_ctrl;
   logic       wr_scratch;

   assign wr_ctrl    = wr_stb_i && (reg_addr_i == REG_CTRL);
   assign wr_scratch = wr_stb_i && (reg_addr_i == REG_SCRATCH);

   // Control register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stall_q  <= CTRL_RESET_VAL[CTRL_STALL_BIT];
         reset_q  <= CTRL_RESET_VAL[CTRL_RESET_BIT];
         evt_en_q <= CTRL_RESET_VAL[CTRL_EVT_EN_BIT];
      end else if (wr_ctrl) begin
         stall_q  <= reg_data_i[CTRL_STALL_BIT];
         reset_q  <= reg_data_i[CTRL_RESET_BIT];
         evt_en_q <= reg_data_i[CTRL_EVT_EN_BIT];
      end
   end

   // Scratch register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         scratch_q <= '0;
      end else if (wr_scratch) begin
         scratch_q <= reg_data_i;
      end
   end

   // Run-cycle counter, wraps 255 to 0
   assign run  = !stall_q && !reset_q;
   assign wrap = run && (count_q == '1);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q   <= '0;
         evt_stb_q <= 1'b0;
      end else begin
         if (run) begin
            count_q <= count_q + 1'b1;
         end
         evt_stb_q <= wrap && evt_en_q;
      end
   end

   // Read mux, unmapped addresses give zero
   always_comb begin
      rd_val = '0;
      case (reg_addr_i)
         REG_CTRL: begin
            rd_val[CTRL_STALL_BIT]  = stall_q;
            rd_val[CTRL_RESET_BIT]  = reset_q;
            rd_val[CTRL_EVT_EN_BIT] = evt_en_q;
         end
         REG_SCRATCH: begin
            rd_val = scratch_q;
         end
         REG_COUNT: begin
            rd_val = count_q;
         end
         REG_TILE_ID: begin
            rd_val = {{(DATA_W-TILE_ID_W){1'b0}}, TILE_ID};
         end
         default: begin
            rd_val = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_stb_q <= 1'b0;
      end else begin
         rsp_stb_q <= rd_stb_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_stb_i) begin
         rsp_data_q <= rd_val;
      end
   end

   assign rsp_stb_o   = rsp_stb_q;
   assign rsp_data_o  = rsp_data_q;
   assign evt_stb_o   = evt_stb_q;
   assign cpu_stall_o = stall_q;
   assign cpu_reset_o = reset_q;

endmodule

// File: rtl/dbg_cmd_decode.sv
// Host command decoder. One command per host strobe, no back-pressure.
// Strobes to the tiles follow the host strobe by one cycle.
// Words of kind KIND_RSP are dropped silently.
`timescale 1ns/10ps

module dbg_cmd_decode (
   input  logic                                 clk,
   input  logic                                 rst_n_i,
   input  logic                                 host_stb_i,
   input  dbg_pkg::dbg_word_t                   host_word_i,
   output logic [dbg_pkg::NUM_TILES-1:0]        wr_stb_o,
   output logic [dbg_pkg::NUM_TILES-1:0]        rd_stb_o,
   output dbg_pkg::dbg_addr_t                   reg_addr_o,
   output dbg_pkg::dbg_data_t                   reg_data_o
);

   import dbg_pkg::*;

   dbg_kind_t              kind;
   tile_id_t               tile;
   logic [NUM_TILES-1:0]   wr_nxt;
   logic [NUM_TILES-1:0]   rd_nxt;
   logic [NUM_TILES-1:0]   wr_q;
   logic [NUM_TILES-1:0]   rd_q;
   dbg_addr_t              addr_q;
   dbg_data_t              data_q;

   // Field split of the incoming word
   assign kind = dbg_kind_t'(host_word_i[WORD_KIND_LSB +: KIND_W]);
   assign tile = host_word_i[WORD_TILE_LSB +: TILE_ID_W];

   // Kind and tile to strobe vectors
   always_comb begin
      wr_nxt = '0;
      rd_nxt = '0;
      if (host_stb_i) begin
         case (kind)
            KIND_WRITE: begin
               wr_nxt[tile] = 1'b1;
            end
            KIND_BCAST: begin
               wr_nxt = '1;
            end
            KIND_READ: begin
               rd_nxt[tile] = 1'b1;
            end
            default: begin
               // Responses are never commands
               wr_nxt = '0;
               rd_nxt = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_q <= '0;
         rd_q <= '0;
      end else begin
         wr_q <= wr_nxt;
         rd_q <= rd_nxt;
      end
   end

   // Address and data only move with a host strobe
   always_ff @(posedge clk) begin
      if (host_stb_i) begin
         addr_q <= host_word_i[WORD_ADDR_LSB +: ADDR_W];
         data_q <= host_word_i[DATA_W-1:0];
      end
   end

   assign wr_stb_o   = wr_q;
   assign rd_stb_o   = rd_q;
   assign reg_addr_o = addr_q;
   assign reg_data_o = data_q;

endmodule

// File: rtl/dbg_pkg.sv
// Shared word formats and register map of the debug-control subsystem.
// Host words are 16 bits: kind, tile, register address, data.
// Widths are fixed here; the four-tile layout assumes TILE_ID_W = 2.
package dbg_pkg;

   // Tile count and index width
   localparam int NUM_TILES = 4;
   localparam int TILE_ID_W = 2;

   // Field widths of a host word
   localparam int WORD_W = 16;
   localparam int KIND_W = 2;
   localparam int ADDR_W = 4;
   localparam int DATA_W = 8;

   // Field positions inside a host word
   localparam int WORD_KIND_LSB = 14;
   localparam int WORD_TILE_LSB = 12;
   localparam int WORD_ADDR_LSB = 8;

   typedef logic [WORD_W-1:0]    dbg_word_t;
   typedef logic [ADDR_W-1:0]    dbg_addr_t;
   typedef logic [DATA_W-1:0]    dbg_data_t;
   typedef logic [TILE_ID_W-1:0] tile_id_t;

   // Command kinds, KIND_RSP only travels towards the host
   typedef enum logic [KIND_W-1:0] {
      KIND_WRITE = 2'd0,
      KIND_READ  = 2'd1,
      KIND_BCAST = 2'd2,
      KIND_RSP   = 2'd3
   } dbg_kind_t;

   // Register map of one tile
   localparam dbg_addr_t REG_CTRL    = 4'd0;
   localparam dbg_addr_t REG_SCRATCH = 4'd1;
   localparam dbg_addr_t REG_COUNT   = 4'd2;
   localparam dbg_addr_t REG_TILE_ID = 4'd3;

   // Address field of an event word
   localparam dbg_addr_t ADDR_EVENT  = 4'd15;

   // Control register bits
   localparam int CTRL_STALL_BIT  = 0;
   localparam int CTRL_RESET_BIT  = 1;
   localparam int CTRL_EVT_EN_BIT = 2;

   // Tile held in reset, not stalled, events off
   localparam dbg_data_t CTRL_RESET_VAL = 8'h02;

endpackage
